/* hdl/sys_defines.svh */
`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// Bus widths.
`define SYS_DATA_W 32
`define SYS_ADDR_W 32
`define SYS_BE_W   4

// Address split into page and register offset.
`define SYS_OFF_W  8
`define SYS_PAGE_W 24

// GPIO pin counts.
`define SYS_GPI_W 13
`define SYS_GPO_W 24

// Address map, one 256-byte page per device.
`define SYS_GPIO_PAGE  24'h800000
`define SYS_TIMER_PAGE 24'h800001

// Timer compare value out of reset, keeps the interrupt quiet.
`define SYS_CMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

/* hdl/sys_pkg.sv */
`include "sys_defines.svh"

package sys_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register offset and bus address views.
  //////////////////////////////////////////////////////////////////////

  // Byte offset of a register inside a device page.
  typedef logic [`SYS_OFF_W-1:0] reg_off_t;

  // One bus address word.
  // The raw view is what the host drives.
  // The fields view is what the fabric decodes.
  typedef union packed {
    logic [`SYS_ADDR_W-1:0] raw;
    struct packed {
      logic [`SYS_PAGE_W-1:0] page;
      reg_off_t               off;
    } fields;
  } bus_addr_u;

endpackage

/* hdl/sys_bus_xbar.sv */
`timescale 1ns/10ps

`include "sys_defines.svh"

module sys_bus_xbar (
  input  logic                   clk_sys_i,
  input  logic                   rst_n_i,

  // Host request.
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [`SYS_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SYS_BE_W-1:0]   req_be_i,
  input  logic [`SYS_DATA_W-1:0] req_wdata_i,

  // Host response.
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SYS_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,

  // Shared device request lines.
  output logic                   gpio_req_o,
  output logic                   tmr_req_o,
  output logic                   dev_we_o,
  output logic [`SYS_BE_W-1:0]   dev_be_o,
  output sys_pkg::reg_off_t      dev_off_o,
  output logic [`SYS_DATA_W-1:0] dev_wdata_o,

  // Device replies.
  input  logic                   gpio_rvalid_i,
  input  logic [`SYS_DATA_W-1:0] gpio_rdata_i,
  input  logic                   gpio_err_i,
  input  logic                   tmr_rvalid_i,
  input  logic [`SYS_DATA_W-1:0] tmr_rdata_i,
  input  logic                   tmr_err_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]             state_q;
  logic [1:0]             state_d;

  // Captured request.
  sys_pkg::bus_addr_u     addr_q;
  logic                   we_q;
  logic [`SYS_BE_W-1:0]   be_q;
  logic [`SYS_DATA_W-1:0] wdata_q;

  logic                   issue_q;
  logic                   miss_q;
  logic                   gpio_sel;
  logic                   tmr_sel;
  logic                   accept;
  logic                   reply;

  logic [`SYS_DATA_W-1:0] merged_rdata;
  logic                   merged_err;
  logic [`SYS_DATA_W-1:0] rsp_rdata_q;
  logic                   rsp_err_q;

  //////////////////////////////////////////////////////////////////////
  // Page decode and device request.
  //////////////////////////////////////////////////////////////////////

  assign accept   = (state_q == ST_IDLE) & req_valid_i;
  assign gpio_sel = (addr_q.fields.page == `SYS_GPIO_PAGE);
  assign tmr_sel  = (addr_q.fields.page == `SYS_TIMER_PAGE);

  // Request pulse goes out the cycle after acceptance.
  assign gpio_req_o  = issue_q & gpio_sel;
  assign tmr_req_o   = issue_q & tmr_sel;
  assign dev_we_o    = we_q;
  assign dev_be_o    = be_q;
  assign dev_off_o   = addr_q.fields.off;
  assign dev_wdata_o = wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Reply merge.
  //////////////////////////////////////////////////////////////////////

  // A miss answers with the same latency as a real device.
  assign reply = gpio_rvalid_i | tmr_rvalid_i | miss_q;

  always_comb begin
    merged_err = miss_q | (gpio_rvalid_i & gpio_err_i) | (tmr_rvalid_i & tmr_err_i);
    merged_rdata = '0;
    if (gpio_rvalid_i) begin
      merged_rdata = merged_rdata | gpio_rdata_i;
    end
    if (tmr_rvalid_i) begin
      merged_rdata = merged_rdata | tmr_rdata_i;
    end
    // Writes and errors carry no data.
    if (merged_err || we_q) begin
      merged_rdata = '0;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = ST_WAIT;
      ST_WAIT: if (reply) state_d = ST_RESP;
      ST_RESP: if (rsp_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      issue_q <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      issue_q <= accept;
      miss_q  <= issue_q & ~gpio_sel & ~tmr_sel;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      addr_q.raw <= req_addr_i;
      we_q       <= req_we_i;
      be_q       <= req_be_i;
      wdata_q    <= req_wdata_i;
    end
    // Held until the host takes it.
    if ((state_q == ST_WAIT) && reply) begin
      rsp_rdata_q <= merged_rdata;
      rsp_err_q   <= merged_err;
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

endmodule

/* hdl/gpio_regs.sv */
`timescale 1ns/10ps

`include "sys_defines.svh"

module gpio_regs (
  input  logic                   clk_sys_i,
  input  logic                   rst_n_i,

  input  logic                   dev_req_i,
  input  logic                   dev_we_i,
  input  logic [`SYS_BE_W-1:0]   dev_be_i,
  input  sys_pkg::reg_off_t      dev_off_i,
  input  logic [`SYS_DATA_W-1:0] dev_wdata_i,
  output logic                   dev_rvalid_o,
  output logic [`SYS_DATA_W-1:0] dev_rdata_o,
  output logic                   dev_err_o,

  input  logic [`SYS_GPI_W-1:0]  gp_i,
  output logic [`SYS_GPO_W-1:0]  gp_o
);

  localparam sys_pkg::reg_off_t GPO_OFF = 8'h00;
  localparam sys_pkg::reg_off_t GPI_OFF = 8'h04;

  logic [`SYS_GPO_W-1:0]  gpo_q;
  logic [`SYS_GPI_W-1:0]  gpi_meta_q;
  logic [`SYS_GPI_W-1:0]  gpi_sync_q;
  logic [`SYS_DATA_W-1:0] gpo_word;
  logic                   gpo_wr;

  logic                   rvalid_q;
  logic [`SYS_DATA_W-1:0] rdata_q;
  logic                   err_q;

  assign gpo_wr = dev_req_i & dev_we_i & (dev_off_i == GPO_OFF);

  // Byte lanes merged into the zero-extended output word.
  always_comb begin
    gpo_word = {{(`SYS_DATA_W-`SYS_GPO_W){1'b0}}, gpo_q};
    for (int i = 0; i < `SYS_BE_W; i++) begin
      if (dev_be_i[i]) begin
        gpo_word[8*i +: 8] = dev_wdata_i[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      if (gpo_wr) begin
        gpo_q <= gpo_word[`SYS_GPO_W-1:0];
      end
      // Two-flop input synchroniser.
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= dev_req_i;
    end
  end

  // Register read mux, answered one cycle after the request.
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i) begin
      err_q   <= 1'b0;
      rdata_q <= '0;
      case (dev_off_i)
        GPO_OFF: if (!dev_we_i) rdata_q <= {{(`SYS_DATA_W-`SYS_GPO_W){1'b0}}, gpo_q};
        GPI_OFF: if (!dev_we_i) rdata_q <= {{(`SYS_DATA_W-`SYS_GPI_W){1'b0}}, gpi_sync_q};
        default: err_q <= 1'b1;
      endcase
    end
  end

  assign dev_rvalid_o = rvalid_q;
  assign dev_rdata_o  = rdata_q;
  assign dev_err_o    = err_q;
  assign gp_o         = gpo_q;

endmodule

/* hdl/timer_regs.sv */
`timescale 1ns/10ps

`include "sys_defines.svh"

module timer_regs (
  input  logic                   clk_sys_i,
  input  logic                   rst_n_i,

  input  logic                   dev_req_i,
  input  logic                   dev_we_i,
  input  logic [`SYS_BE_W-1:0]   dev_be_i,
  input  sys_pkg::reg_off_t      dev_off_i,
  input  logic [`SYS_DATA_W-1:0] dev_wdata_i,
  output logic                   dev_rvalid_o,
  output logic [`SYS_DATA_W-1:0] dev_rdata_o,
  output logic                   dev_err_o,

  output logic                   timer_irq_o
);

  localparam sys_pkg::reg_off_t MTIME_LO_OFF = 8'h00;
  localparam sys_pkg::reg_off_t MTIME_HI_OFF = 8'h04;
  localparam sys_pkg::reg_off_t CMP_LO_OFF   = 8'h08;
  localparam sys_pkg::reg_off_t CMP_HI_OFF   = 8'h0C;

  logic [63:0]            mtime_q;
  logic [63:0]            mtime_d;
  logic [63:0]            cmp_q;
  logic [63:0]            cmp_d;
  logic                   irq_q;
  logic                   wr;

  logic                   rvalid_q;
  logic [`SYS_DATA_W-1:0] rdata_q;
  logic                   err_q;

  // Byte-enabled update of one 32-bit half.
  function automatic logic [`SYS_DATA_W-1:0] merge_be(
    input logic [`SYS_DATA_W-1:0] old_val,
    input logic [`SYS_DATA_W-1:0] wdata,
    input logic [`SYS_BE_W-1:0]   be
  );
    logic [`SYS_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `SYS_BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign wr = dev_req_i & dev_we_i;

  //////////////////////////////////////////////////////////////////////
  // Counter and compare update.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // A counter write replaces this cycle's increment.
    mtime_d = mtime_q + 64'd1;
    cmp_d   = cmp_q;
    if (wr) begin
      case (dev_off_i)
        MTIME_LO_OFF: mtime_d = {mtime_q[63:32], merge_be(mtime_q[31:0], dev_wdata_i, dev_be_i)};
        MTIME_HI_OFF: mtime_d = {merge_be(mtime_q[63:32], dev_wdata_i, dev_be_i), mtime_q[31:0]};
        CMP_LO_OFF:   cmp_d   = {cmp_q[63:32], merge_be(cmp_q[31:0], dev_wdata_i, dev_be_i)};
        CMP_HI_OFF:   cmp_d   = {merge_be(cmp_q[63:32], dev_wdata_i, dev_be_i), cmp_q[31:0]};
        default:      cmp_d   = cmp_q;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      mtime_q  <= '0;
      cmp_q    <= `SYS_CMP_RESET;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      mtime_q  <= mtime_d;
      cmp_q    <= cmp_d;
      irq_q    <= (mtime_q >= cmp_q);
      rvalid_q <= dev_req_i;
    end
  end

  // Register read, one cycle after the request.
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i) begin
      err_q <= 1'b0;
      case (dev_off_i)
        MTIME_LO_OFF: rdata_q <= mtime_q[31:0];
        MTIME_HI_OFF: rdata_q <= mtime_q[63:32];
        CMP_LO_OFF:   rdata_q <= cmp_q[31:0];
        CMP_HI_OFF:   rdata_q <= cmp_q[63:32];
        default: begin
          rdata_q <= '0;
          err_q   <= 1'b1;
        end
      endcase
    end
  end

  assign dev_rvalid_o = rvalid_q;
  assign dev_rdata_o  = rdata_q;
  assign dev_err_o    = err_q;
  assign timer_irq_o  = irq_q;

endmodule

/* hdl/sys_top.sv */
`timescale 1ns/10ps

`include "sys_defines.svh"

module sys_top (
  input  logic                   clk_sys_i,
  input  logic                   rst_n_i,

  // Host port.
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [`SYS_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SYS_BE_W-1:0]   req_be_i,
  input  logic [`SYS_DATA_W-1:0] req_wdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SYS_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,

  // Pins and interrupt.
  input  logic [`SYS_GPI_W-1:0]  gp_i,
  output logic [`SYS_GPO_W-1:0]  gp_o,
  output logic                   timer_irq_o
);

  //////////////////////////////////////////////////////////////////////
  // Fabric to device wiring.
  //////////////////////////////////////////////////////////////////////

  logic                   gpio_req;
  logic                   tmr_req;
  logic                   dev_we;
  logic [`SYS_BE_W-1:0]   dev_be;
  sys_pkg::reg_off_t      dev_off;
  logic [`SYS_DATA_W-1:0] dev_wdata;

  logic                   gpio_rvalid;
  logic [`SYS_DATA_W-1:0] gpio_rdata;
  logic                   gpio_err;
  logic                   tmr_rvalid;
  logic [`SYS_DATA_W-1:0] tmr_rdata;
  logic                   tmr_err;

  sys_bus_xbar u_xbar (
    .clk_sys_i     (clk_sys_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_addr_i    (req_addr_i),
    .req_we_i      (req_we_i),
    .req_be_i      (req_be_i),
    .req_wdata_i   (req_wdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o),
    .gpio_req_o    (gpio_req),
    .tmr_req_o     (tmr_req),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_off_o     (dev_off),
    .dev_wdata_o   (dev_wdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .gpio_err_i    (gpio_err),
    .tmr_rvalid_i  (tmr_rvalid),
    .tmr_rdata_i   (tmr_rdata),
    .tmr_err_i     (tmr_err)
  );

  gpio_regs u_gpio (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .dev_req_i    (gpio_req),
    .dev_we_i     (dev_we),
    .dev_be_i     (dev_be),
    .dev_off_i    (dev_off),
    .dev_wdata_i  (dev_wdata),
    .dev_rvalid_o (gpio_rvalid),
    .dev_rdata_o  (gpio_rdata),
    .dev_err_o    (gpio_err),
    .gp_i         (gp_i),
    .gp_o         (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .dev_req_i    (tmr_req),
    .dev_we_i     (dev_we),
    .dev_be_i     (dev_be),
    .dev_off_i    (dev_off),
    .dev_wdata_i  (dev_wdata),
    .dev_rvalid_o (tmr_rvalid),
    .dev_rdata_o  (tmr_rdata),
    .dev_err_o    (tmr_err),
    .timer_irq_o  (timer_irq_o)
  );

endmodule

/* bench/tb_sys_top.sv */
`timescale 1ns/10ps

`include "sys_defines.svh"

module tb_sys_top;

  localparam int NUM_TXN        = 400;
  localparam int MAX_TXN_CYCLES = 12;
  localparam int RESET_CYCLES   = 8;
  // Worst-case run length plus a quarter of margin.
  localparam int TIMEOUT_CYCLES = NUM_TXN * MAX_TXN_CYCLES * 5 / 4;
  localparam int KIND_EXACT     = 0;
  localparam int KIND_CNT_LO    = 1;

  logic                   clk_sys;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  logic [`SYS_ADDR_W-1:0] req_addr;
  logic                   req_we;
  logic [`SYS_BE_W-1:0]   req_be;
  logic [`SYS_DATA_W-1:0] req_wdata;
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`SYS_DATA_W-1:0] rsp_rdata;
  logic                   rsp_err;
  logic [`SYS_GPI_W-1:0]  gp_in;
  logic [`SYS_GPO_W-1:0]  gp_out;
  logic                   timer_irq;

  // Reference model.
  logic [`SYS_GPO_W-1:0]  gpo_model;
  logic [63:0]            cmp_model;
  logic [31:0]            cnt_lo_min;
  logic [31:0]            cnt_hi_model;
  logic [31:0]            exp_data_q[$];
  logic                   exp_err_q[$];
  int                     exp_kind_q[$];

  logic [31:0]            rng_state;
  int                     value_errs;
  int                     proto_errs;
  int                     txn_count;
  int                     cycle_count = 0;
  int                     req_xfers = 0;
  int                     rsp_xfers = 0;

  sys_top dut (
    .clk_sys_i   (clk_sys),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_addr_i  (req_addr),
    .req_we_i    (req_we),
    .req_be_i    (req_be),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .gp_i        (gp_in),
    .gp_o        (gp_out),
    .timer_irq_o (timer_irq)
  );

  initial clk_sys = 1'b0;
  always #2 clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d transactions issued", cycle_count, txn_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // A response needs a request that has not been answered yet.
  always @(posedge clk_sys) begin
    if (rst_n && req_valid && req_ready) begin
      req_xfers = req_xfers + 1;
    end
    if (rst_n && rsp_valid && rsp_ready) begin
      rsp_xfers = rsp_xfers + 1;
      assert (rsp_xfers <= req_xfers) else begin
        $display("A response was transferred with no request outstanding");
        proto_errs++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers.
  //////////////////////////////////////////////////////////////////////

  // Xorshift32.
  function logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] apply_byte_enables(input logic [31:0] old_val,
                                                     input logic [31:0] wdata,
                                                     input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] make_addr(input logic [23:0] page, input logic [7:0] off);
    sys_pkg::bus_addr_u a;
    a.fields.page = page;
    a.fields.off  = off;
    return a.raw;
  endfunction

  function automatic logic [31:0] gpo_word();
    return {{(`SYS_DATA_W-`SYS_GPO_W){1'b0}}, gpo_model};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_response();
    logic [31:0] exp_data;
    logic        exp_err;
    int          kind;
    exp_data = exp_data_q.pop_front();
    exp_err  = exp_err_q.pop_front();
    kind     = exp_kind_q.pop_front();
    compare_word("rsp_err_o", {31'd0, exp_err}, {31'd0, rsp_err});
    if (kind == KIND_CNT_LO) begin
      assert (rsp_rdata >= cnt_lo_min) else begin
        $display("ERROR %0t rsp_rdata_o expected >= %h got %h", $time, cnt_lo_min, rsp_rdata);
        value_errs++;
      end
      cnt_lo_min = rsp_rdata;
    end else begin
      compare_word("rsp_rdata_o", exp_data, rsp_rdata);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the response.
  task automatic run_transaction(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                 input logic [31:0] wdata, input logic [31:0] exp_data,
                                 input logic exp_err, input int kind);
    int          edges;
    bit          seen_valid;
    bit          done;
    logic [31:0] held_data;
    logic        held_err;
    assert (req_ready) else begin
      $display("Request port was not ready while the bus was idle");
      proto_errs++;
    end
    req_valid = 1'b1;
    req_addr  = addr;
    req_we    = we;
    req_be    = be;
    req_wdata = wdata;
    while (!req_ready) @(negedge clk_sys);
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_kind_q.push_back(kind);
    txn_count++;
    @(negedge clk_sys);
    req_valid  = 1'b0;
    edges      = 1;
    seen_valid = 1'b0;
    done       = 1'b0;
    while (!done) begin
      assert (!req_ready) else begin
        $display("Request port was ready while a response was pending");
        proto_errs++;
      end
      rsp_ready = ((next_random() % 10) < 7);
      if (rsp_valid) begin
        if (!seen_valid) begin
          // Valid in time for the third edge after the request transfer.
          assert (edges == 3) else begin
            $display("Response became valid %0d edges after its request, not 3", edges);
            proto_errs++;
          end
          seen_valid = 1'b1;
          held_data  = rsp_rdata;
          held_err   = rsp_err;
        end else begin
          assert (rsp_rdata === held_data && rsp_err === held_err) else begin
            $display("Response payload changed before the host took it");
            proto_errs++;
          end
        end
        if (rsp_ready) begin
          check_response();
          done = 1'b1;
        end
      end else begin
        assert (!seen_valid) else begin
          $display("Response valid dropped before the host took it");
          proto_errs++;
        end
      end
      @(negedge clk_sys);
      edges++;
    end
    compare_word("gp_o", gpo_word(), {{(`SYS_DATA_W-`SYS_GPO_W){1'b0}}, gp_out});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////////////////////////

  task automatic irq_check(input logic below);
    if (below) begin
      cmp_model = {cnt_hi_model, 32'h0};
      run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h0C), 1'b1, 4'hF, cnt_hi_model, '0, 1'b0,
                      KIND_EXACT);
      run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h08), 1'b1, 4'hF, '0, '0, 1'b0, KIND_EXACT);
    end else begin
      cmp_model = '1;
      run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h08), 1'b1, 4'hF, '1, '0, 1'b0, KIND_EXACT);
      run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h0C), 1'b1, 4'hF, '1, '0, 1'b0, KIND_EXACT);
    end
    run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h08), 1'b0, 4'hF, '0, cmp_model[31:0], 1'b0,
                    KIND_EXACT);
    compare_word("timer_irq_o", {31'd0, below}, {31'd0, timer_irq});
  endtask

  task automatic random_step();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] word;
    logic [3:0]  be;
    logic [23:0] page;
    logic [7:0]  off;
    r    = next_random();
    d    = next_random();
    be   = r[11:8];
    page = d[31:8];
    off  = d[7:0];
    case (r[3:0])
      4'd0, 4'd1, 4'd2: begin
        word      = apply_byte_enables(gpo_word(), d, be);
        gpo_model = word[`SYS_GPO_W-1:0];
        run_transaction(make_addr(`SYS_GPIO_PAGE, 8'h00), 1'b1, be, d, '0, 1'b0, KIND_EXACT);
      end
      4'd3, 4'd4: begin
        run_transaction(make_addr(`SYS_GPIO_PAGE, 8'h00), 1'b0, be, d, gpo_word(), 1'b0,
                        KIND_EXACT);
      end
      4'd5: begin
        // Input register ignores writes.
        run_transaction(make_addr(`SYS_GPIO_PAGE, 8'h04), 1'b1, be, d, '0, 1'b0, KIND_EXACT);
      end
      4'd6: begin
        gp_in = d[`SYS_GPI_W-1:0];
        repeat (4) @(negedge clk_sys);
        run_transaction(make_addr(`SYS_GPIO_PAGE, 8'h04), 1'b0, be, '0,
                        {{(`SYS_DATA_W-`SYS_GPI_W){1'b0}}, gp_in}, 1'b0, KIND_EXACT);
      end
      4'd7: begin
        if (page == `SYS_GPIO_PAGE || page == `SYS_TIMER_PAGE) begin
          page = page ^ 24'h000100;
        end
        run_transaction(make_addr(page, off), r[4], be, d, '0, 1'b1, KIND_EXACT);
      end
      4'd8: begin
        if (r[5]) begin
          if (off inside {8'h00, 8'h04}) off = off | 8'h10;
          run_transaction(make_addr(`SYS_GPIO_PAGE, off), r[4], be, d, '0, 1'b1, KIND_EXACT);
        end else begin
          if (off inside {8'h00, 8'h04, 8'h08, 8'h0C}) off = off | 8'h10;
          run_transaction(make_addr(`SYS_TIMER_PAGE, off), r[4], be, d, '0, 1'b1, KIND_EXACT);
        end
      end
      4'd9, 4'd10: begin
        if (r[4]) begin
          cmp_model[63:32] = apply_byte_enables(cmp_model[63:32], d, be);
        end else begin
          cmp_model[31:0] = apply_byte_enables(cmp_model[31:0], d, be);
        end
        run_transaction(make_addr(`SYS_TIMER_PAGE, r[4] ? 8'h0C : 8'h08), 1'b1, be, d, '0, 1'b0,
                        KIND_EXACT);
      end
      4'd11: begin
        run_transaction(make_addr(`SYS_TIMER_PAGE, r[4] ? 8'h0C : 8'h08), 1'b0, be, '0,
                        r[4] ? cmp_model[63:32] : cmp_model[31:0], 1'b0, KIND_EXACT);
      end
      4'd12: begin
        // Low word kept small so it never carries into the high word.
        if (r[4]) begin
          cnt_hi_model = d;
          run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h04), 1'b1, 4'hF, d, '0, 1'b0, KIND_EXACT);
        end else begin
          cnt_lo_min = {1'b0, d[30:0]};
          run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h00), 1'b1, 4'hF, cnt_lo_min, '0, 1'b0,
                          KIND_EXACT);
        end
      end
      4'd13, 4'd14: begin
        if (r[4]) begin
          run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h04), 1'b0, be, '0, cnt_hi_model, 1'b0,
                          KIND_EXACT);
        end else begin
          run_transaction(make_addr(`SYS_TIMER_PAGE, 8'h00), 1'b0, be, '0, '0, 1'b0,
                          KIND_CNT_LO);
        end
      end
      default: irq_check(r[4]);
    endcase
  endtask

  initial begin
    rng_state    = 32'd2;
    value_errs   = 0;
    proto_errs   = 0;
    txn_count    = 0;
    gpo_model    = '0;
    cmp_model    = `SYS_CMP_RESET;
    cnt_lo_min   = '0;
    cnt_hi_model = '0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_we       = 1'b0;
    req_be       = '0;
    req_wdata    = '0;
    rsp_ready    = 1'b0;
    gp_in        = '0;
    repeat (RESET_CYCLES) @(negedge clk_sys);
    rst_n = 1'b1;
    @(negedge clk_sys);
    compare_word("req_ready_o", 32'd1, {31'd0, req_ready});
    compare_word("rsp_valid_o", 32'd0, {31'd0, rsp_valid});
    compare_word("timer_irq_o", 32'd0, {31'd0, timer_irq});
    compare_word("gp_o", 32'd0, {{(`SYS_DATA_W-`SYS_GPO_W){1'b0}}, gp_out});
    while (txn_count < NUM_TXN) begin
      random_step();
    end
    $display("Done: %0d transactions, %0d value errors, %0d protocol errors",
             txn_count, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/sys_pkg.sv
hdl/sys_bus_xbar.sv
hdl/gpio_regs.sv
hdl/timer_regs.sv
hdl/sys_top.sv
bench/tb_sys_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_sys_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

SOURCES   := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
